// File: Bender.yml
package:
  name: wavegen

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/waveGenPkg.sv
      - src/sineLookup.sv
      - src/waveSequencer.sv
      - src/waveGen.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/waveGenProperties.sv
      - dv/waveGenTb.sv

// File: common/waveGenPkg.sv
`default_nettype none

package waveGenPkg;

    `include "waveGen_cfg.svh"

    // one output sample.
    typedef logic [`SAMPLE_WIDTH-1:0] sample_t;

    // phase shared by sine and square.
    typedef logic [`PHASE_WIDTH-1:0] phase_t;

    // address into the quarter-wave table, 0 to 128.
    typedef logic [7:0] quadAddr_t;

    // waveform selector driven on fsel.
    typedef enum logic [1:0] {
        WaveSine     = 2'd0,
        WaveSquare   = 2'd1,
        WaveTriangle = 2'd2,
        WaveSaw      = 2'd3
    } waveSel_e;

    // triangle direction.
    typedef enum logic {
        SlopeUp   = 1'b0,
        SlopeDown = 1'b1
    } slopeDir_e;

endpackage

`default_nettype wire

// File: common/waveGen_cfg.svh
`ifndef WAVEGEN_CFG_SVH
`define WAVEGEN_CFG_SVH

// width of one output sample.
`define SAMPLE_WIDTH 8

// phase counter width, 512 phases per sine period.
`define PHASE_WIDTH 9

// quarter-wave table covers phases 0 to 128 inclusive.
`define QUAD_ENTRIES 129

// full-scale sample.
`define SAMPLE_MAX 255

// square output toggles once per this many edges.
`define SQUARE_HALF 128

`endif

// File: dv/waveGenProperties.sv
`timescale 1ns/1ns
`default_nettype none

module waveGenProperties
    import waveGenPkg::*;
(
    input logic      dbClock,
    input logic      arstN,
    input waveSel_e  fsel,
    input sample_t   db,
    input phase_t    phase,
    input slopeDir_e slope
);

    int assertFailures = 0;

    // sawtooth wraps 255 to 0.
    sawStep: assert property (
        @(negedge dbClock) disable iff (!arstN)
        fsel == WaveSaw |=> db == sample_t'($past(db) + sample_t'(1))
    ) else begin
        assertFailures++;
        $error("sawtooth did not advance by one");
    end

    phaseHold: assert property (
        @(negedge dbClock) disable iff (!arstN)
        (fsel == WaveTriangle || fsel == WaveSaw) |=> phase == $past(phase)
    ) else begin
        assertFailures++;
        $error("phase moved outside sine and square modes");
    end

    // direction comes from the slope flag before the edge.
    triangleStep: assert property (
        @(negedge dbClock) disable iff (!arstN)
        fsel == WaveTriangle |=>
            db == (($past(slope) == SlopeUp) ? sample_t'($past(db) + sample_t'(1))
                                             : sample_t'($past(db) - sample_t'(1)))
    ) else begin
        assertFailures++;
        $error("triangle step was not one in the slope direction");
    end

    resetClear: assert property (
        @(negedge dbClock) !arstN |-> db == '0
    ) else begin
        assertFailures++;
        $error("sample not cleared during reset");
    end

endmodule

bind waveSequencer waveGenProperties props_i (
    .dbClock (dbClock),
    .arstN   (arstN),
    .fsel    (fsel),
    .db      (db),
    .phase   (phase),
    .slope   (slope)
);

`default_nettype wire

// File: dv/waveGenTb.sv
`timescale 1ns/1ns
`default_nettype none

module waveGenTb
    import waveGenPkg::*;
();

    localparam int          HalfPeriod    = 4;
    localparam int          TimeoutCycles = 4000;
    localparam logic [31:0] RngSeed       = 32'd28537;
    localparam int          SawEdges      = 300;
    localparam int          TriangleEdges = 520;
    localparam int          SquareEdges   = 512;
    localparam int          SineEdges     = 512;

    logic     dbClock;
    logic     arstN;
    waveSel_e fsel;
    sample_t  db;

    int          errorCount;
    int          assertCount;
    int          cycleCount;
    logic [31:0] rngState;

    // one sine period from the DUT indexed by phase.
    sample_t sineRec [SineEdges];

    waveGen dut_i (
        .dbClock (dbClock),
        .arstN   (arstN),
        .fsel    (fsel),
        .db      (db)
    );

    always #HalfPeriod dbClock = ~dbClock;

    always @(posedge dbClock) begin
        cycleCount++;
        if (cycleCount >= TimeoutCycles) begin
            $display("Simulation timed out after %0d cycles", cycleCount);
            $display("Some tests failed");
            $finish;
        end
    end

    function automatic logic [31:0] nextRandom(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic checkSample(input string testName, input sample_t expected,
                               input sample_t actual);
        if (actual !== expected) begin
            errorCount++;
            $display("Error %s: expected %0d, actual %0d", testName, expected, actual);
        end
    endtask

    task automatic noteFailure(input string what);
        errorCount++;
        $display("%s", what);
    endtask

    // leaves the bench 1 ns after a rising edge with the DUT out of reset.
    task automatic applyReset(input waveSel_e sel);
        @(posedge dbClock);
        #1;
        fsel  = sel;
        arstN = 1'b0;
        repeat (3) @(posedge dbClock);
        #1;
        arstN = 1'b1;
    endtask

    // one falling edge; db is read 1 ns before the next rising edge.
    task automatic stepEdge(input waveSel_e sel, output sample_t s);
        fsel = sel;
        @(negedge dbClock);
        #3;
        s = db;
        @(posedge dbClock);
        #1;
    endtask

    // step with the old slope, then turn at 254 or 1.
    task automatic advanceTriangle(inout sample_t level, inout logic rising);
        sample_t stepped;
        if (rising) begin
            stepped = level + sample_t'(1);
        end else begin
            stepped = level - sample_t'(1);
        end
        if (level == 8'd254) begin
            rising = 1'b0;
        end else if (level == 8'd1) begin
            rising = 1'b1;
        end
        level = stepped;
    endtask

    task automatic resetClearsSample();
        sample_t  s;
        waveSel_e sel;
        string    tag;
        for (int m = 0; m < 4; m++) begin
            sel = waveSel_e'(m);
            tag = $sformatf("reset %s", sel.name());
            applyReset(sel);
            checkSample(tag, sample_t'(0), db);
            repeat (5) stepEdge(sel, s);
            applyReset(sel);
            checkSample(tag, sample_t'(0), db);
        end
    endtask

    task automatic sawtoothRamp();
        sample_t s;
        applyReset(WaveSaw);
        for (int k = 0; k < SawEdges; k++) begin
            stepEdge(WaveSaw, s);
            checkSample("sawtooth", sample_t'((k + 1) % 256), s);
        end
    endtask

    task automatic triangleSweep();
        sample_t s;
        sample_t expected;
        logic    rising;
        applyReset(WaveTriangle);
        expected = '0;
        rising   = 1'b1;
        for (int k = 1; k <= TriangleEdges; k++) begin
            advanceTriangle(expected, rising);
            stepEdge(WaveTriangle, s);
            checkSample("triangle", expected, s);
            if (k == 255) begin
                checkSample("triangle peak", 8'd255, s);
            end
            if (k == 510) begin
                checkSample("triangle floor", 8'd0, s);
            end
        end
    endtask

    task automatic squareToggle();
        sample_t s;
        sample_t expected;
        applyReset(WaveSquare);
        for (int k = 0; k < SquareEdges; k++) begin
            stepEdge(WaveSquare, s);
            expected = ((k / 128) % 2 == 0) ? 8'd255 : 8'd0;
            checkSample("square", expected, s);
        end
    endtask

    task automatic sineSymmetry();
        sample_t s;
        sample_t expected;
        applyReset(WaveSine);
        for (int k = 0; k < SineEdges; k++) begin
            stepEdge(WaveSine, s);
            sineRec[k] = s;
        end

        checkSample("sine phase 0", 8'd127, sineRec[0]);
        checkSample("sine phase 128", 8'd255, sineRec[128]);
        checkSample("sine phase 256", 8'd127, sineRec[256]);
        checkSample("sine phase 384", 8'd0, sineRec[384]);

        // second quarter mirrors the first.
        for (int k = 1; k < 128; k++) begin
            checkSample("sine mirror", sineRec[k], sineRec[256 - k]);
        end

        for (int k = 0; k < 256; k++) begin
            if (sineRec[k] > 8'd254) begin
                expected = '0;
            end else begin
                expected = 8'd254 - sineRec[k];
            end
            checkSample("sine lower half", expected, sineRec[256 + k]);
        end

        for (int k = 1; k <= 128; k++) begin
            if (sineRec[k] < sineRec[k - 1]) begin
                noteFailure($sformatf("Sine first quarter decreases at phase %0d", k));
            end
        end
    endtask

    // sawtooth in between must leave the sine phase where it was.
    task automatic sineResumesPhase();
        sample_t s;
        sample_t expected;
        int      n;
        int      m;
        rngState = nextRandom(rngState);
        n        = 1 + int'(rngState % 199);
        rngState = nextRandom(rngState);
        m        = 1 + int'(rngState % 40);
        $display("Mode switch: %0d sine edges, then %0d sawtooth edges", n, m);

        applyReset(WaveSine);
        for (int k = 0; k < n; k++) begin
            stepEdge(WaveSine, s);
            checkSample("sine before switch", sineRec[k], s);
        end

        expected = sineRec[n - 1];
        for (int k = 0; k < m; k++) begin
            expected = expected + sample_t'(1);
            stepEdge(WaveSaw, s);
            checkSample("sawtooth after sine", expected, s);
        end

        for (int k = 0; k < 8; k++) begin
            stepEdge(WaveSine, s);
            checkSample("sine after switch", sineRec[n + k], s);
        end
    endtask

    task automatic triangleResumesSlope();
        sample_t s;
        sample_t expected;
        logic    rising;
        int      steps;
        applyReset(WaveTriangle);
        expected = '0;
        rising   = 1'b1;
        steps    = 0;
        while ((rising || expected >= 8'd200) && steps < 600) begin
            advanceTriangle(expected, rising);
            stepEdge(WaveTriangle, s);
            checkSample("triangle before switch", expected, s);
            steps++;
        end
        if (steps >= 600) begin
            noteFailure("Triangle never fell below 200 before the mode switch");
        end

        // slope flag is held while the sawtooth runs.
        for (int k = 0; k < 3; k++) begin
            expected = expected + sample_t'(1);
            stepEdge(WaveSaw, s);
            checkSample("sawtooth inside triangle", expected, s);
        end

        for (int k = 0; k < 20; k++) begin
            advanceTriangle(expected, rising);
            stepEdge(WaveTriangle, s);
            checkSample("triangle after switch", expected, s);
        end
    endtask

    initial begin
        dbClock    = 1'b0;
        arstN      = 1'b1;
        fsel       = WaveSine;
        errorCount = 0;
        cycleCount = 0;
        rngState   = RngSeed;

        resetClearsSample();
        sawtoothRamp();
        triangleSweep();
        squareToggle();
        sineSymmetry();
        sineResumesPhase();
        triangleResumesSlope();

        assertCount = dut_i.seq_i.props_i.assertFailures;
        $display("Finished with %0d check errors and %0d assertion failures",
                 errorCount, assertCount);
        if (errorCount == 0 && assertCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src/sineLookup.sv
`timescale 1ns/1ns
`default_nettype none

`include "waveGen_cfg.svh"

module sineLookup
    import waveGenPkg::*;
(
    input  phase_t  phase,
    output sample_t sineSample
);

    // first quarter of the period, phases 0 to 128, nondecreasing.
    localparam sample_t QuarterWave [`QUAD_ENTRIES] = '{
        8'd127, 8'd129, 8'd130, 8'd132, 8'd133, 8'd135, 8'd136, 8'd138,
        8'd140, 8'd141, 8'd143, 8'd144, 8'd146, 8'd147, 8'd149, 8'd150,
        8'd152, 8'd154, 8'd155, 8'd157, 8'd158, 8'd160, 8'd161, 8'd163,
        8'd164, 8'd166, 8'd167, 8'd169, 8'd170, 8'd172, 8'd173, 8'd175,
        8'd176, 8'd177, 8'd179, 8'd180, 8'd182, 8'd183, 8'd185, 8'd186,
        8'd187, 8'd189, 8'd190, 8'd191, 8'd193, 8'd194, 8'd195, 8'd197,
        8'd198, 8'd199, 8'd201, 8'd202, 8'd203, 8'd205, 8'd206, 8'd207,
        8'd208, 8'd209, 8'd211, 8'd212, 8'd213, 8'd214, 8'd215, 8'd216,
        8'd218, 8'd219, 8'd220, 8'd221, 8'd222, 8'd223, 8'd224, 8'd225,
        8'd226, 8'd227, 8'd228, 8'd229, 8'd230, 8'd231, 8'd232, 8'd233,
        8'd233, 8'd234, 8'd235, 8'd236, 8'd237, 8'd238, 8'd238, 8'd239,
        8'd240, 8'd241, 8'd241, 8'd242, 8'd243, 8'd243, 8'd244, 8'd245,
        8'd245, 8'd246, 8'd246, 8'd247, 8'd248, 8'd248, 8'd249, 8'd249,
        8'd249, 8'd250, 8'd250, 8'd251, 8'd251, 8'd252, 8'd252, 8'd252,
        8'd253, 8'd253, 8'd253, 8'd253, 8'd254, 8'd254, 8'd254, 8'd254,
        8'd254, 8'd255, 8'd255, 8'd255, 8'd255, 8'd255, 8'd255, 8'd255,
        8'd255
    };

    // lower half is reflected about 127, i.e. 254 minus the upper value.
    localparam sample_t LowerBase = sample_t'(`SAMPLE_MAX - 1);

    // phase within the half period, 0 to 255.
    logic [7:0] halfPhase;

    // set for phases 256 to 511.
    logic       lowerHalf;

    quadAddr_t  addr;
    sample_t    quarter;

    assign halfPhase = phase[7:0];
    assign lowerHalf = phase[`PHASE_WIDTH-1];

    // fold the second quarter back onto the first.
    always_comb begin
        if (halfPhase <= 8'd128) begin
            addr = quadAddr_t'(halfPhase);
        end else begin
            addr = quadAddr_t'(9'd256 - {1'b0, halfPhase});
        end
    end

    assign quarter = QuarterWave[addr];

    // upper half straight from the table.
    // lower half floors at 0, only the 255 entries would go negative.
    always_comb begin
        if (!lowerHalf) begin
            sineSample = quarter;
        end else if (quarter > LowerBase) begin
            sineSample = '0;
        end else begin
            sineSample = LowerBase - quarter;
        end
    end

endmodule

`default_nettype wire

// File: src/waveGen.sv
`timescale 1ns/1ns
`default_nettype none

module waveGen
    import waveGenPkg::*;
(
    input  logic     dbClock,
    input  logic     arstN,
    input  waveSel_e fsel,
    output sample_t  db
);

    // phase from the sequencer into the sine table.
    phase_t  phase;

    // sine value for the current phase, ready before the next edge.
    sample_t sineSample;

    // owns every register: sample, phase and triangle slope.
    waveSequencer seq_i (
        .dbClock    (dbClock),
        .arstN      (arstN),
        .fsel       (fsel),
        .sineSample (sineSample),
        .phase      (phase),
        .db         (db)
    );

    // purely combinational lookup.
    sineLookup sine_i (
        .phase      (phase),
        .sineSample (sineSample)
    );

endmodule

`default_nettype wire

// File: src/waveSequencer.sv
`timescale 1ns/1ns
`default_nettype none

`include "waveGen_cfg.svh"

module waveSequencer
    import waveGenPkg::*;
(
    input  logic     dbClock,
    input  logic     arstN,
    input  waveSel_e fsel,
    input  sample_t  sineSample,
    output phase_t   phase,
    output sample_t  db
);

    sample_t   dbNext;
    phase_t    phaseNext;
    slopeDir_e slope;
    slopeDir_e slopeNext;

    // square toggles when the phase is on a half-period boundary.
    logic      squareEdge;

    // triangle turning points, one step short of the extremes.
    logic      atTop;
    logic      atBottom;

    assign squareEdge = (phase % `PHASE_WIDTH'(`SQUARE_HALF)) == '0;
    assign atTop      = db == sample_t'(`SAMPLE_MAX - 1);
    assign atBottom   = db == sample_t'(1);

    // next-sample rules.
    // all modes share the one output register, so a mode change picks up
    // from whatever sample is currently on db.
    always_comb begin
        dbNext    = db;
        phaseNext = phase;
        slopeNext = slope;

        case (fsel)
            WaveSine: begin
                dbNext    = sineSample;
                phaseNext = phase + phase_t'(1);
            end

            WaveSquare: begin
                if (squareEdge) begin
                    dbNext = sample_t'(`SAMPLE_MAX) - db;
                end
                phaseNext = phase + phase_t'(1);
            end

            WaveTriangle: begin
                // step uses the slope from before the edge.
                if (slope == SlopeUp) begin
                    dbNext = db + sample_t'(1);
                end else begin
                    dbNext = db - sample_t'(1);
                end

                if (atTop) begin
                    slopeNext = SlopeDown;
                end else if (atBottom) begin
                    slopeNext = SlopeUp;
                end
            end

            WaveSaw: begin
                // wraps 255 to 0 on its own.
                dbNext = db + sample_t'(1);
            end

            default: begin
                dbNext = db;
            end
        endcase
    end

    // sample register, updated on the falling edge.
    always_ff @(negedge dbClock or negedge arstN) begin
        if (!arstN) begin
            db <= '0;
        end else begin
            db <= dbNext;
        end
    end

    // phase counter, wraps at 512.
    always_ff @(negedge dbClock or negedge arstN) begin
        if (!arstN) begin
            phase <= '0;
        end else begin
            phase <= phaseNext;
        end
    end

    // triangle slope flag.
    always_ff @(negedge dbClock or negedge arstN) begin
        if (!arstN) begin
            slope <= SlopeUp;
        end else begin
            slope <= slopeNext;
        end
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+common
common/waveGenPkg.sv
src/sineLookup.sv
src/waveSequencer.sv
src/waveGen.sv
dv/waveGenProperties.sv
dv/waveGenTb.sv
